// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  localparam int XLEN      = 32;   // datapath width
  localparam int NUM_REGS  = 16;   // x0..x15
  localparam int REG_AW    = 4;    // register index width
  localparam int ROM_DEPTH = 256;  // instruction words
  localparam int ROM_AW    = 8;    // pc width, word addressed

  // major opcodes, anything else is illegal
  typedef enum logic [3:0] {
    OP_ADDI = 4'h0,  // rd = rs1 + sext(imm)
    OP_ADD  = 4'h1,  // rd = rs1 + rs2
    OP_LW   = 4'h4,  // rd = mem[rs1 + sext(imm)]
    OP_SW   = 4'h5,  // mem[rs1 + sext(imm)] = rs2
    OP_HALT = 4'hA   // park the core
  } opcode_e;

  // instruction word, msb first
  typedef struct packed {
    logic [11:0]       imm;     // signed immediate
    logic [REG_AW-1:0] rs2;     // second source
    logic [REG_AW-1:0] rs1;     // first source, also address base
    logic [REG_AW-1:0] rd;      // destination
    logic [3:0]        opt;     // reserved, not decoded
    opcode_e           opcode;  // low nibble
  } instr_t;

  // core sequencer states
  typedef enum logic [2:0] {
    S_FETCH,        // pc on rom address
    S_DECODE,       // rom word into ir
    S_EXEC,         // alu op and writeback, or load request regs
    S_MEM_REQ,      // req high, waiting for ack
    S_MEM_RELEASE,  // req low, waiting for ack to drop
    S_HALT          // parked until reset
  } core_state_e;

endpackage

// ==== common/bus_pkg.sv ====
package bus_pkg;

  localparam int MEM_AW       = 8;    // data ram word address bits
  localparam int MEM_DEPTH    = 256;  // data ram words
  localparam int DEFAULT_WAIT = 8;    // wait states before ack

  // master to slave, held stable while req is high
  typedef struct packed {
    logic              we;     // 1 = store, 0 = load
    logic [MEM_AW-1:0] addr;   // word address
    logic [31:0]       wdata;  // store data
  } mem_req_t;

  // slave to master, valid while ack is high
  typedef struct packed {
    logic [31:0] rdata;  // load data
  } mem_rsp_t;

endpackage

// ==== cpu/gr_file.sv ====
`timescale 1ns/1ps

module gr_file
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [REG_AW-1:0] rd_addr_a,
  input  logic [REG_AW-1:0] rd_addr_b,
  output logic [XLEN-1:0]   rd_data_a,
  output logic [XLEN-1:0]   rd_data_b,
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [XLEN-1:0]   wr_data,
  input  logic [REG_AW-1:0] dbg_addr,
  output logic [XLEN-1:0]   dbg_data
);

  logic [XLEN-1:0] x [NUM_REGS];  // x[0] never written

  // shared by all three read ports
  function automatic logic [XLEN-1:0] rd_reg(input logic [REG_AW-1:0] idx);
    return (idx == '0) ? '0 : x[idx];  // x0 hardwired
  endfunction

  // reads follow both the index and the array contents
  always_comb begin
    rd_data_a = rd_reg(rd_addr_a);
    rd_data_b = rd_reg(rd_addr_b);
    dbg_data  = rd_reg(dbg_addr);  // host readback
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        x[i] <= '0;  // every restart starts clean
      end
    end else if (wr_en && wr_addr != '0) begin
      x[wr_addr] <= wr_data;  // x0 writes dropped
    end
  end

endmodule

// ==== cpu/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
  import cpu_pkg::*, bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  output logic [ROM_AW-1:0] fetch_addr,
  input  instr_t            instr,
  output logic [REG_AW-1:0] rd_addr_a,
  output logic [REG_AW-1:0] rd_addr_b,
  input  logic [XLEN-1:0]   rd_data_a,
  input  logic [XLEN-1:0]   rd_data_b,
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_addr,
  output logic [XLEN-1:0]   wr_data,
  output mem_req_t          mem_req,
  output logic              req,
  input  mem_rsp_t          mem_rsp,
  input  logic              ack,
  output logic              halted,
  output logic              illegal
);

  core_state_e       state;     // sequencer
  logic [ROM_AW-1:0] pc;        // word address of current instruction
  instr_t            ir;        // instruction register
  logic [XLEN-1:0]   imm_sext;  // sign extended immediate
  logic [XLEN-1:0]   opnd_b;    // second adder input
  logic [XLEN-1:0]   sum;       // alu result or effective address
  logic              is_mem;    // lw or sw in ir

  assign fetch_addr = pc;  // rom registers it, word shows up in S_DECODE
  assign rd_addr_a  = ir.rs1;
  assign rd_addr_b  = ir.rs2;
  assign halted     = (state == S_HALT);

  assign is_mem   = (ir.opcode == OP_LW) || (ir.opcode == OP_SW);
  assign imm_sext = {{(XLEN-12){ir.imm[11]}}, ir.imm};
  assign opnd_b   = (ir.opcode == OP_ADD) ? rd_data_b : imm_sext;  // add uses rs2
  assign sum      = rd_data_a + opnd_b;  // single adder for alu and address

  // writeback, alu result in S_EXEC, load data on ack
  always_comb begin
    wr_en   = 1'b0;
    wr_addr = ir.rd;
    wr_data = sum;
    if (state == S_EXEC && (ir.opcode == OP_ADDI || ir.opcode == OP_ADD)) begin
      wr_en = 1'b1;
    end else if (state == S_MEM_REQ && ack && !mem_req.we) begin
      wr_en   = 1'b1;
      wr_data = mem_rsp.rdata;  // sampled while ack is high
    end
  end

  // payload regs, only loaded while req is low
  always_ff @(posedge clk) begin
    if (state == S_DECODE) begin
      ir <= instr;
    end
    if (state == S_EXEC && is_mem) begin
      mem_req.we    <= (ir.opcode == OP_SW);
      mem_req.addr  <= sum[MEM_AW-1:0];  // ram sees low address bits only
      mem_req.wdata <= rd_data_b;        // rs2 for stores
    end
  end

  // sequencer and four-phase master
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_FETCH;
      pc      <= '0;
      req     <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        S_FETCH:  state <= S_DECODE;
        S_DECODE: state <= S_EXEC;
        S_EXEC: begin
          case (ir.opcode)
            OP_ADDI, OP_ADD: begin
              pc    <= pc + 1'b1;
              state <= S_FETCH;
            end
            OP_LW, OP_SW: begin
              req   <= 1'b1;  // request regs load on the same edge
              state <= S_MEM_REQ;
            end
            OP_HALT: state <= S_HALT;
            default: begin
              illegal <= 1'b1;  // unknown opcode
              state   <= S_HALT;
            end
          endcase
        end
        S_MEM_REQ: begin
          if (ack) begin  // stall here until the slave answers
            req   <= 1'b0;
            state <= S_MEM_RELEASE;
          end
        end
        S_MEM_RELEASE: begin
          if (!ack) begin  // handshake closed, next req may rise
            pc    <= pc + 1'b1;
            state <= S_FETCH;
          end
        end
        default: state <= S_HALT;  // S_HALT parks until rst
      endcase
    end
  end

endmodule

// ==== hdl/inst_rom.sv ====
`timescale 1ns/1ps

module inst_rom
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              prog_we,
  input  logic [ROM_AW-1:0] prog_addr,
  input  instr_t            prog_data,
  input  logic [ROM_AW-1:0] fetch_addr,
  output instr_t            instr
);

  instr_t mem [ROM_DEPTH];  // program store, kept across core resets

  // host load port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // core read port, one cycle latency
  always_ff @(posedge clk) begin
    instr <= mem[fetch_addr];
  end

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram
  import bus_pkg::*;
#(
  parameter int WAIT = DEFAULT_WAIT  // cycles from req rise to ack rise, 1..15
) (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t mem_req,
  input  logic     req,
  output mem_rsp_t mem_rsp,
  output logic     ack
);

  logic [31:0] mem [MEM_DEPTH];  // storage
  logic [3:0]  cnt;              // cycles since req rose
  logic        fire;             // counter expired, do the access

  assign fire = req && !ack && (cnt == 4'(WAIT - 1));

  // handshake slave
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      ack <= 1'b0;
    end else if (fire) begin
      cnt <= '0;
      ack <= 1'b1;  // hold until req drops
    end else if (req && !ack) begin
      cnt <= cnt + 1'b1;  // counting wait states
    end else if (ack && !req) begin
      ack <= 1'b0;  // master released, close the handshake
    end
  end

  // access happens on the same edge that raises ack
  always_ff @(posedge clk) begin
    if (fire) begin
      if (mem_req.we) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end
      mem_rsp.rdata <= mem[mem_req.addr];  // read data, don't care on stores
    end
  end

endmodule

// ==== hdl/mother_board.sv ====
`timescale 1ns/1ps

module mother_board
  import cpu_pkg::*, bus_pkg::*;
#(
  parameter int WAIT = DEFAULT_WAIT  // data ram wait states
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              prog_we,
  input  logic [ROM_AW-1:0] prog_addr,
  input  instr_t            prog_data,
  input  logic [REG_AW-1:0] dbg_addr,
  output logic [XLEN-1:0]   dbg_data,
  output logic              halted,
  output logic              illegal
);

  logic [ROM_AW-1:0] fetch_addr;  // core to rom
  instr_t            instr;       // rom to core
  logic [REG_AW-1:0] rd_addr_a;
  logic [REG_AW-1:0] rd_addr_b;
  logic [XLEN-1:0]   rd_data_a;
  logic [XLEN-1:0]   rd_data_b;
  logic              wr_en;
  logic [REG_AW-1:0] wr_addr;
  logic [XLEN-1:0]   wr_data;
  mem_req_t          mem_req;     // data bus request
  mem_rsp_t          mem_rsp;     // data bus response
  logic              req;
  logic              ack;

  cpu_core cpu (
    .clk, .rst,
    .fetch_addr, .instr,
    .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .wr_en, .wr_addr, .wr_data,
    .mem_req, .req, .mem_rsp, .ack,
    .halted, .illegal
  );

  gr_file gr_file (
    .clk, .rst,
    .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .wr_en, .wr_addr, .wr_data,
    .dbg_addr, .dbg_data
  );

  inst_rom rom (
    .clk,
    .prog_we, .prog_addr, .prog_data,
    .fetch_addr, .instr
  );

  data_ram #(.WAIT(WAIT)) ram (
    .clk, .rst,
    .mem_req, .req,
    .mem_rsp, .ack
  );

endmodule

// ==== test/cpu_sva.sv ====
`timescale 1ns/1ps

module cpu_sva
  import bus_pkg::*;
#(
  parameter int WAIT = DEFAULT_WAIT  // wait states of the bound ram
) (
  input logic     clk,
  input logic     rst,
  input logic     req,
  input logic     ack,
  input mem_req_t mem_req,
  input logic     halted
);

  int sva_errors = 0;  // failed assertion count

  // next req only after the previous ack dropped
  req_rise_ack_low: assert property (@(posedge clk) disable iff (rst)
    $rose(req) |-> !$past(ack))
  else begin
    $error("req rose while ack was still high");
    sva_errors++;
  end

  req_payload_stable: assert property (@(posedge clk) disable iff (rst)
    req && $past(req) |-> $stable(mem_req))
  else begin
    $error("mem_req changed while req was high");
    sva_errors++;
  end

  // ack rises WAIT cycles after req rises, and at no other time
  ack_wait_count: assert property (@(posedge clk) disable iff (rst)
    ($past(req, WAIT) && !$past(req, WAIT + 1)) == $rose(ack))
  else begin
    $error("ack did not rise exactly %0d cycles after req", WAIT);
    sva_errors++;
  end

  // first reset cycle still shows the old state
  quiet_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |-> !halted && !req && !ack)
  else begin
    $error("halted, req or ack high during reset");
    sva_errors++;
  end

endmodule

bind mother_board cpu_sva #(.WAIT(WAIT)) u_cpu_sva (
  .clk, .rst, .req, .ack, .mem_req, .halted
);

// ==== test/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
  import cpu_pkg::*;
(
  input logic [XLEN-1:0] dbg_data,  // register readback port of the board
  input logic            illegal    // illegal opcode flag of the board
);

  string cur_name;        // test in progress
  int    cur_errors;      // problems seen in it
  int    test_count = 0;
  int    pass_count = 0;
  int    fail_count = 0;

  task automatic start_test(input string name);
    cur_name   = name;
    cur_errors = 0;
  endtask

  // dbg_addr already driven by the caller
  task automatic check_reg(input int idx, input logic [XLEN-1:0] expected);
    if (dbg_data !== expected) begin
      $display("Error %s x%0d expected 0x%08h actual 0x%08h",
               cur_name, idx, expected, dbg_data);
      cur_errors++;
    end
  endtask

  task automatic check_flag(input logic expected);
    if (illegal !== expected) begin
      $display("Error %s illegal expected %0d actual %0d",
               cur_name, expected, illegal);
      cur_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s: %s", cur_name, msg);
    cur_errors++;
  endtask

  task automatic finish_test();
    test_count++;
    if (cur_errors == 0) begin
      pass_count++;
      $display("PASS %s", cur_name);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d problem(s)", cur_name, cur_errors);
    end
  endtask

  task automatic report_counts();
    $display("%0d tests run, %0d passed, %0d failed", test_count, pass_count, fail_count);
  endtask

endmodule

// ==== test/tb_int_cpu_mem.sv ====
`timescale 1ns/1ps

module tb_int_cpu_mem
  import cpu_pkg::*;
();

  localparam int HALT_TIMEOUT = 2000;  // cycles a program may run
  localparam int RESET_CYCLES = 16;

  logic              clk = 1'b0;
  logic              rst;
  logic              prog_we;
  logic [ROM_AW-1:0] prog_addr;
  instr_t            prog_data;
  logic [REG_AW-1:0] dbg_addr;
  logic [XLEN-1:0]   dbg_data;
  logic              halted;
  logic              illegal;

  string           test_name;           // current block of the stimulus file
  logic [31:0]     prog_words [$];      // program image
  int              exp_idx [$];         // registers to read back
  logic [XLEN-1:0] exp_val [$];
  logic            exp_illegal;
  bit              setup_ok = 1'b1;     // file opened and parsed cleanly

  always #4 clk = ~clk;  // 8 ns period

  mother_board #(.WAIT(8)) i_mother_board (
    .clk, .rst, .prog_we, .prog_addr, .prog_data,
    .dbg_addr, .dbg_data, .halted, .illegal
  );

  cpu_checker chk (
    .dbg_data, .illegal
  );

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);  // rest of a comment line
    end
  endtask

  // one block: test, prog, regs, illegal
  task automatic read_block(input int fd, output bit got);
    string       tok;
    int          n;
    int          m;
    int          idx;
    int          flag;
    int          hits;
    logic [31:0] word;
    bit          done;
    got  = 1'b0;
    done = 1'b0;
    n    = 0;
    m    = 0;
    while (!done) begin
      if ($fscanf(fd, " %s", tok) != 1) begin
        done = 1'b1;  // end of file
      end else if (tok.substr(0, 0) == "#") begin
        skip_line(fd);
      end else if (tok == "test") begin
        prog_words.delete();
        exp_idx.delete();
        exp_val.delete();
        hits = $fscanf(fd, " %s prog %d", test_name, n);
        for (int i = 0; i < n; i++) begin
          hits += $fscanf(fd, " %h", word);
          prog_words.push_back(word);
        end
        hits += $fscanf(fd, " regs %d", m);
        for (int i = 0; i < m; i++) begin
          hits += $fscanf(fd, " %d %h", idx, word);
          exp_idx.push_back(idx);
          exp_val.push_back(word);
        end
        hits += $fscanf(fd, " illegal %d", flag);
        exp_illegal = (flag != 0);
        got  = (hits == 2 + n + 1 + 2 * m + 1);
        done = 1'b1;
        if (!got) begin
          $display("stimulus block %s is malformed", test_name);
          setup_ok = 1'b0;
        end
      end else begin
        $display("stimulus file has an unexpected token %s", tok);
        setup_ok = 1'b0;
        done     = 1'b1;
      end
    end
  endtask

  // rst high for at least 16 cycles, rom written meanwhile
  task automatic load_program();
    int ncyc;
    ncyc = (prog_words.size() > RESET_CYCLES) ? prog_words.size() : RESET_CYCLES;
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < ncyc; i++) begin
      prog_we = (i < prog_words.size());
      if (i < prog_words.size()) begin
        prog_addr = ROM_AW'(i);
        prog_data = instr_t'(prog_words[i]);
      end
      @(negedge clk);
    end
    prog_we = 1'b0;
    rst     = 1'b0;
  endtask

  task automatic wait_halt(output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      seen = halted;  // registered output, settled by now
      cycles++;
    end
  endtask

  task automatic read_back();
    chk.check_flag(exp_illegal);
    for (int k = 0; k < exp_idx.size(); k++) begin
      dbg_addr = REG_AW'(exp_idx[k]);  // on a falling edge
      @(negedge clk);
      chk.check_reg(exp_idx[k], exp_val[k]);  // one full cycle after the address
    end
  endtask

  task automatic run_test();
    bit seen;
    chk.start_test(test_name);
    load_program();
    wait_halt(seen);
    if (seen) begin
      read_back();
    end else begin
      chk.note_failure($sformatf("halted did not rise within %0d cycles", HALT_TIMEOUT));
    end
    chk.finish_test();
  endtask

  initial begin
    int fd;
    bit got;
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    dbg_addr  = '0;
    fd = $fopen("test/cpu_mem_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open test/cpu_mem_stimulus.txt");
      setup_ok = 1'b0;
    end else begin
      read_block(fd, got);
      while (got) begin
        run_test();
        read_block(fd, got);
      end
      $fclose(fd);
    end
    chk.report_counts();
    if (setup_ok && chk.test_count > 0 && chk.fail_count == 0 &&
        i_mother_board.u_cpu_sva.sva_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== test/cpu_mem_stimulus.txt ====
# test <name> / prog <n> <hex words> / regs <n> <index hex-value pairs> / illegal <0|1>
# word fields: imm[31:20] rs2[19:16] rs1[15:12] rd[11:8] opt[7:4] opcode[3:0]

# addi chain with a negative immediate, addi into x0 dropped
test addi_chain
prog 6 00500100 12301200 FFD02300 00701000 FFF00400 0000000A
regs 5 1 00000005 2 00000128 3 00000125 0 00000000 4 FFFFFFFF
illegal 0

# sw x1 to 0x10 then lw back into x3
test store_load
prog 5 05500100 01000200 00012005 00002304 0000000A
regs 3 1 00000055 2 00000010 3 00000055
illegal 0

# two stores to address 4, load sees the later one
test overwrite
prog 6 11100100 22200200 00410005 00420005 00400304 0000000A
regs 3 1 00000111 2 00000222 3 00000222
illegal 0

# stores to 0x20 and 0x21, loads in reverse order, add wraps
test two_addresses
prog 9 02000100 3AB00200 F0000300 00021005 00131005 00101404 00001504 00054601 0000000A
regs 5 1 00000020 3 FFFFFF00 4 FFFFFF00 5 000003AB 6 000002AB
illegal 0

# opcode 3 parks the core, the addi after it never runs
test illegal_opcode
prog 4 07700700 00000003 00100800 0000000A
regs 2 7 00000077 8 00000000
illegal 1

# fresh load after reset, nothing left from earlier programs
test restart_clean
prog 2 00900900 0000000A
regs 6 1 00000000 3 00000000 5 00000000 6 00000000 7 00000000 9 00000009
illegal 0

// ==== cpu_mem.f ====
common/cpu_pkg.sv
common/bus_pkg.sv
cpu/gr_file.sv
cpu/cpu_core.sv
hdl/inst_rom.sv
hdl/data_ram.sv
hdl/mother_board.sv
test/cpu_sva.sv
test/cpu_checker.sv
test/tb_int_cpu_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build tb_int_cpu_mem with verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_int_cpu_mem \
  -f cpu_mem.f --Mdir obj_dir -o sim_cpu_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_cpu_mem)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" <<< "$sim_out"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
